// File: all.f
+incdir+rtl
rtl/hdc_pkg.sv
rtl/axil_regs.sv
rtl/hv_generator.sv
rtl/item_memory.sv
rtl/item_lookup_stream.sv
rtl/hdc_top.sv
verification/tb_hdc_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the item-memory testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_hdc_top -Mdir obj_dir

./obj_dir/Vtb_hdc_top | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// File: verification/tb_hdc_top.sv
`timescale 1ns/1ps

`include "hdc_defs.svh"

module tb_hdc_top;

    localparam int WAIT_LIMIT = 200;
    localparam int POLL_LIMIT = 50;
    localparam int NUM_ITEMS  = 6;
    localparam int RAND_BEATS = 24;

    logic                 AXIS_ACLK;
    logic                 S_AXI_ARESETN;
    logic [31:0]          S_AXI_AWADDR;
    logic                 S_AXI_AWVALID;
    logic                 S_AXI_AWREADY;
    logic [31:0]          S_AXI_WDATA;
    logic [3:0]           S_AXI_WSTRB;
    logic                 S_AXI_WVALID;
    logic                 S_AXI_WREADY;
    logic                 S_AXI_BREADY;
    logic [1:0]           S_AXI_BRESP;
    logic                 S_AXI_BVALID;
    logic [31:0]          S_AXI_ARADDR;
    logic                 S_AXI_ARVALID;
    logic                 S_AXI_ARREADY;
    logic                 S_AXI_RREADY;
    logic [31:0]          S_AXI_RDATA;
    logic [1:0]           S_AXI_RRESP;
    logic                 S_AXI_RVALID;
    logic [`HV_WIDTH-1:0] S_AXIS_TDATA;
    logic                 S_AXIS_TLAST;
    logic                 S_AXIS_TVALID;
    logic                 S_AXIS_TREADY;
    logic [`HV_WIDTH-1:0] M_AXIS_TDATA;
    logic                 M_AXIS_TLAST;
    logic                 M_AXIS_TVALID;
    logic                 M_AXIS_TREADY;

    // expected beats, in order of acceptance
    hdc_pkg::hv_beat_t    exp_q[$];
    hdc_pkg::hv_beat_t    exp_beat;
    int                   send_q[$];
    logic [`HV_WIDTH-1:0] model_hv [NUM_ITEMS];
    // one counter per checking process
    int                   check_errors;
    int                   beat_errors;
    int                   hold_errors;
    int                   idle_errors;
    int                   timeouts;
    logic                 run_off;
    logic                 stream_busy;

    hdc_top u_dut (.*);

    // 20 ns clock
    initial AXIS_ACLK = 1'b0;
    always #10 AXIS_ACLK = ~AXIS_ACLK;

    // --------------------
    // reference model
    // --------------------

    // xorshift32, shifts 13 left / 17 right / 5 left
    function automatic logic [31:0] next_rand(input logic [31:0] v);
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // item i word k is output i*8+k+1 after the seed, word 0 lowest
    task automatic build_model();
        logic [31:0] x;
        x = `XORSHIFT_SEED;
        for (int i = 0; i < NUM_ITEMS; i++) begin
            for (int k = 0; k < `HV_WORDS; k++) begin
                x = next_rand(x);
                model_hv[i][k*`WORD_WIDTH +: `WORD_WIDTH] = x;
            end
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got == exp) else begin
            $display("Error: %s got %h, expected %h", name, got, exp);
            check_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: no progress while waiting for %s", what);
        timeouts++;
    endtask

    // --------------------
    // axi-lite master
    // --------------------
    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        int   waited;
        logic done;
        @(negedge AXIS_ACLK);
        S_AXI_AWADDR  = addr;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WDATA   = data;
        S_AXI_WSTRB   = 4'hf;
        S_AXI_WVALID  = 1'b1;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < WAIT_LIMIT) begin
            #1;
            if (S_AXI_AWREADY && S_AXI_WREADY) begin
                done = 1'b1;
            end else begin
                @(negedge AXIS_ACLK);
                waited++;
            end
        end
        if (!done) report_timeout("AWREADY and WREADY");
        @(negedge AXIS_ACLK);
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b1;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < WAIT_LIMIT) begin
            #1;
            if (S_AXI_BVALID) begin
                done = 1'b1;
                compare_value("S_AXI_BRESP", 32'(S_AXI_BRESP), 32'h0);
            end else begin
                @(negedge AXIS_ACLK);
                waited++;
            end
        end
        if (!done) report_timeout("BVALID");
        @(negedge AXIS_ACLK);
        S_AXI_BREADY = 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        int   waited;
        logic done;
        data = '0;
        @(negedge AXIS_ACLK);
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < WAIT_LIMIT) begin
            #1;
            if (S_AXI_ARREADY) begin
                done = 1'b1;
            end else begin
                @(negedge AXIS_ACLK);
                waited++;
            end
        end
        if (!done) report_timeout("ARREADY");
        @(negedge AXIS_ACLK);
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b1;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < WAIT_LIMIT) begin
            #1;
            if (S_AXI_RVALID) begin
                done = 1'b1;
                data = S_AXI_RDATA;
                compare_value("S_AXI_RRESP", 32'(S_AXI_RRESP), 32'h0);
                // ar1 then ar2, so one idle cycle
                compare_value("RVALID latency", 32'(waited), 32'd1);
            end else begin
                @(negedge AXIS_ACLK);
                waited++;
            end
        end
        if (!done) report_timeout("RVALID");
        @(negedge AXIS_ACLK);
        S_AXI_RREADY = 1'b0;
    endtask

    // --------------------
    // stream source
    // --------------------

    // drains send_q, one index per beat, tlast on the final one
    task automatic send_stream();
        int                          n;
        int                          waited;
        logic                        taken;
        hdc_pkg::hv_beat_t           beat;
        n = send_q.size();
        for (int j = 0; j < n; j++) begin
            @(negedge AXIS_ACLK);
            // junk above the index bits
            S_AXIS_TDATA       = '0;
            S_AXIS_TDATA[31:0] = $urandom();
            S_AXIS_TDATA[`ITEM_ADDR_WIDTH-1:0] = `ITEM_ADDR_WIDTH'(send_q[j]);
            S_AXIS_TLAST       = (j == n - 1);
            S_AXIS_TVALID      = 1'b1;
            waited = 0;
            taken  = 1'b0;
            while (!taken && waited < WAIT_LIMIT) begin
                #1;
                if (S_AXIS_TREADY) begin
                    taken = 1'b1;
                end else begin
                    @(negedge AXIS_ACLK);
                    waited++;
                end
            end
            if (taken) begin
                beat.data = model_hv[send_q[j]];
                beat.last = S_AXIS_TLAST;
                exp_q.push_back(beat);
            end else begin
                report_timeout("S_AXIS_TREADY");
            end
        end
        @(negedge AXIS_ACLK);
        S_AXIS_TVALID = 1'b0;
        S_AXIS_TLAST  = 1'b0;
        send_q.delete();
        stream_busy = 1'b0;
    endtask

    // random sink back-pressure while the source runs
    task automatic shake_ready();
        int cycles;
        cycles = 0;
        while (stream_busy && cycles < WAIT_LIMIT * RAND_BEATS) begin
            @(negedge AXIS_ACLK);
            M_AXIS_TREADY = 1'($urandom());
            cycles++;
        end
        M_AXIS_TREADY = 1'b1;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge AXIS_ACLK);
            waited++;
        end
        if (exp_q.size() != 0) report_timeout("output beats to drain");
    endtask

    // --------------------
    // checkers
    // --------------------

    // a transfer happens on the next rising edge
    always @(negedge AXIS_ACLK) begin
        #1;
        if (S_AXI_ARESETN && M_AXIS_TVALID && M_AXIS_TREADY) begin
            if (exp_q.size() == 0) begin
                $display("output beat appeared with no index sent for it");
                beat_errors++;
            end else begin
                exp_beat = exp_q.pop_front();
                assert (M_AXIS_TDATA == exp_beat.data) else begin
                    $display("Error: M_AXIS_TDATA got %h, expected %h",
                             M_AXIS_TDATA, exp_beat.data);
                    beat_errors++;
                end
                assert (M_AXIS_TLAST == exp_beat.last) else begin
                    $display("Error: M_AXIS_TLAST got %h, expected %h",
                             M_AXIS_TLAST, exp_beat.last);
                    beat_errors++;
                end
            end
        end
    end

    // beat holds under back-pressure
    hold_check: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        (M_AXIS_TVALID && !M_AXIS_TREADY) |=>
            (M_AXIS_TVALID && $stable(M_AXIS_TDATA) && $stable(M_AXIS_TLAST)))
    else begin
        $display("Error: M_AXIS_TDATA not held while stalled, now %h, tlast %h",
                 M_AXIS_TDATA, M_AXIS_TLAST);
        hold_errors++;
    end

    // run off means no input accept and no output
    idle_check: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        run_off |-> (!S_AXIS_TREADY && !M_AXIS_TVALID))
    else begin
        $display("Error: S_AXIS_TREADY %h, M_AXIS_TVALID %h, expected 0 with run off",
                 S_AXIS_TREADY, M_AXIS_TVALID);
        idle_errors++;
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        int          polls;
        logic [31:0] rd_val;
        void'($urandom(50662));
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        S_AXIS_TDATA  = '0;
        S_AXIS_TLAST  = 1'b0;
        S_AXIS_TVALID = 1'b0;
        M_AXIS_TREADY = 1'b0;
        check_errors  = 0;
        beat_errors   = 0;
        hold_errors   = 0;
        idle_errors   = 0;
        timeouts      = 0;
        run_off       = 1'b0;
        stream_busy   = 1'b0;
        build_model();

        repeat (16) @(posedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        S_AXI_ARESETN = 1'b1;

        // idle state out of reset
        @(negedge AXIS_ACLK);
        #1;
        compare_value("S_AXI_BVALID", 32'(S_AXI_BVALID), 32'h0);
        compare_value("S_AXI_RVALID", 32'(S_AXI_RVALID), 32'h0);
        compare_value("M_AXIS_TVALID", 32'(M_AXIS_TVALID), 32'h0);
        compare_value("S_AXIS_TREADY", 32'(S_AXIS_TREADY), 32'h0);
        read_reg(32'(`REG_MODE_ADDR), rd_val);
        compare_value("mode register", rd_val, 32'h0);

        // count register and an unmapped address
        write_reg(32'(`REG_COUNT_ADDR), 32'd5);
        read_reg(32'(`REG_COUNT_ADDR), rd_val);
        compare_value("item_count register", rd_val, 32'd5);
        read_reg(32'h8, rd_val);
        compare_value("unmapped register", rd_val, 32'h0);

        // gen, then poll until it clears itself
        write_reg(32'(`REG_MODE_ADDR), 32'h1);
        polls  = 0;
        rd_val = 32'h1;
        while (rd_val[0] && polls < POLL_LIMIT) begin
            read_reg(32'(`REG_MODE_ADDR), rd_val);
            polls++;
        end
        if (rd_val[0]) report_timeout("gen to clear");
        compare_value("mode register after gen", rd_val, 32'h0);

        // run, every item once in order
        write_reg(32'(`REG_MODE_ADDR), 32'h2);
        M_AXIS_TREADY = 1'b1;
        for (int i = 0; i < NUM_ITEMS; i++) send_q.push_back(i);
        stream_busy = 1'b1;
        send_stream();
        wait_drain();

        // random indices under random back-pressure
        for (int i = 0; i < RAND_BEATS; i++) send_q.push_back(int'($urandom % NUM_ITEMS));
        stream_busy = 1'b1;
        fork
            send_stream();
            shake_ready();
        join
        wait_drain();

        // run cleared, offered beats must sit
        write_reg(32'(`REG_MODE_ADDR), 32'h0);
        run_off = 1'b1;
        for (int i = 0; i < 10; i++) begin
            @(negedge AXIS_ACLK);
            S_AXIS_TDATA[31:0] = $urandom();
            S_AXIS_TVALID      = 1'b1;
        end
        @(negedge AXIS_ACLK);
        S_AXIS_TVALID = 1'b0;
        run_off       = 1'b0;
        repeat (2) @(negedge AXIS_ACLK);

        $display("errors: check %0d, beat %0d, hold %0d, idle %0d, timeouts %0d",
                 check_errors, beat_errors, hold_errors, idle_errors, timeouts);
        if (check_errors + beat_errors + hold_errors + idle_errors + timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: rtl/hdc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_defs.svh"

module hdc_top (
    input  logic                 AXIS_ACLK,
    input  logic                 S_AXI_ARESETN,

    // --------------------
    // axi-lite slave
    // --------------------
    input  logic [31:0]          S_AXI_AWADDR,
    input  logic                 S_AXI_AWVALID,
    output logic                 S_AXI_AWREADY,
    input  logic [31:0]          S_AXI_WDATA,
    input  logic [3:0]           S_AXI_WSTRB,
    input  logic                 S_AXI_WVALID,
    output logic                 S_AXI_WREADY,
    input  logic                 S_AXI_BREADY,
    output logic [1:0]           S_AXI_BRESP,
    output logic                 S_AXI_BVALID,
    input  logic [31:0]          S_AXI_ARADDR,
    input  logic                 S_AXI_ARVALID,
    output logic                 S_AXI_ARREADY,
    input  logic                 S_AXI_RREADY,
    output logic [31:0]          S_AXI_RDATA,
    output logic [1:0]           S_AXI_RRESP,
    output logic                 S_AXI_RVALID,

    // --------------------
    // axi-stream ports
    // --------------------
    input  logic [`HV_WIDTH-1:0] S_AXIS_TDATA,
    input  logic                 S_AXIS_TLAST,
    input  logic                 S_AXIS_TVALID,
    output logic                 S_AXIS_TREADY,
    output logic [`HV_WIDTH-1:0] M_AXIS_TDATA,
    output logic                 M_AXIS_TLAST,
    output logic                 M_AXIS_TVALID,
    input  logic                 M_AXIS_TREADY
);

    hdc_pkg::hdc_ctrl_t          ctrl;
    hdc_pkg::hv_write_t          wr;
    logic                        gen_done;
    logic [`ITEM_ADDR_WIDTH-1:0] rd_addr;
    logic [`HV_WIDTH-1:0]        rd_data;

    // register slave
    axil_regs u_axil_regs (
        .AXIS_ACLK(AXIS_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
        .S_AXI_AWADDR(S_AXI_AWADDR), .S_AXI_AWVALID(S_AXI_AWVALID),
        .S_AXI_AWREADY(S_AXI_AWREADY),
        .S_AXI_WDATA(S_AXI_WDATA), .S_AXI_WSTRB(S_AXI_WSTRB),
        .S_AXI_WVALID(S_AXI_WVALID), .S_AXI_WREADY(S_AXI_WREADY),
        .S_AXI_BREADY(S_AXI_BREADY), .S_AXI_BRESP(S_AXI_BRESP),
        .S_AXI_BVALID(S_AXI_BVALID),
        .S_AXI_ARADDR(S_AXI_ARADDR), .S_AXI_ARVALID(S_AXI_ARVALID),
        .S_AXI_ARREADY(S_AXI_ARREADY),
        .S_AXI_RREADY(S_AXI_RREADY), .S_AXI_RDATA(S_AXI_RDATA),
        .S_AXI_RRESP(S_AXI_RRESP), .S_AXI_RVALID(S_AXI_RVALID),
        .gen_done(gen_done), .ctrl(ctrl)
    );

    // random hypervectors during gen
    hv_generator u_hv_generator (
        .AXIS_ACLK(AXIS_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
        .ctrl(ctrl), .wr(wr), .gen_done(gen_done)
    );

    // item storage
    item_memory u_item_memory (
        .AXIS_ACLK(AXIS_ACLK), .wr(wr), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    // index in, hypervector out
    item_lookup_stream u_item_lookup_stream (
        .AXIS_ACLK(AXIS_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN), .ctrl(ctrl),
        .S_AXIS_TDATA(S_AXIS_TDATA), .S_AXIS_TLAST(S_AXIS_TLAST),
        .S_AXIS_TVALID(S_AXIS_TVALID), .S_AXIS_TREADY(S_AXIS_TREADY),
        .M_AXIS_TDATA(M_AXIS_TDATA), .M_AXIS_TLAST(M_AXIS_TLAST),
        .M_AXIS_TVALID(M_AXIS_TVALID), .M_AXIS_TREADY(M_AXIS_TREADY),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// File: rtl/item_lookup_stream.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_defs.svh"

module item_lookup_stream (
    input  logic                         AXIS_ACLK,
    input  logic                         S_AXI_ARESETN,
    input  hdc_pkg::hdc_ctrl_t           ctrl,

    // index stream in
    input  logic [`HV_WIDTH-1:0]         S_AXIS_TDATA,
    input  logic                         S_AXIS_TLAST,
    input  logic                         S_AXIS_TVALID,
    output logic                         S_AXIS_TREADY,

    // hypervector stream out
    output logic [`HV_WIDTH-1:0]         M_AXIS_TDATA,
    output logic                         M_AXIS_TLAST,
    output logic                         M_AXIS_TVALID,
    input  logic                         M_AXIS_TREADY,

    // item memory read
    output logic [`ITEM_ADDR_WIDTH-1:0]  rd_addr,
    input  logic [`HV_WIDTH-1:0]         rd_data
);

    hdc_pkg::hv_beat_t out_beat;
    logic              in_fire;

    // accept only in run, and when the output slot frees up
    assign S_AXIS_TREADY = ctrl.run && (!M_AXIS_TVALID || M_AXIS_TREADY);
    assign in_fire       = S_AXIS_TVALID && S_AXIS_TREADY;

    // item index in the low bits
    assign rd_addr = S_AXIS_TDATA[`ITEM_ADDR_WIDTH-1:0];

    // --------------------
    // output register
    // --------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            M_AXIS_TVALID <= 1'b0;
        end else if (in_fire) begin
            M_AXIS_TVALID <= 1'b1;
        end else if (M_AXIS_TREADY) begin
            M_AXIS_TVALID <= 1'b0;
        end
    end

    // beat payload, held while stalled
    always_ff @(posedge AXIS_ACLK) begin
        if (in_fire) begin
            out_beat <= '{data: rd_data, last: S_AXIS_TLAST};
        end
    end

    assign M_AXIS_TDATA = out_beat.data;
    assign M_AXIS_TLAST = out_beat.last;

    // beat must hold under back-pressure
    a_stall_stable: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        (M_AXIS_TVALID && !M_AXIS_TREADY) |=>
            (M_AXIS_TVALID && $stable(M_AXIS_TDATA) && $stable(M_AXIS_TLAST)));

endmodule

`default_nettype wire

// File: rtl/item_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_defs.svh"

module item_memory (
    input  logic                        AXIS_ACLK,
    input  hdc_pkg::hv_write_t          wr,
    input  logic [`ITEM_ADDR_WIDTH-1:0] rd_addr,
    output logic [`HV_WIDTH-1:0]        rd_data
);

    // --------------------
    // storage
    // --------------------

    // one hypervector per item
    logic [`HV_WIDTH-1:0] mem [`ITEM_DEPTH];

    // write port, fed by the generator
    always_ff @(posedge AXIS_ACLK) begin
        if (wr.valid) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // --------------------
    // lookup
    // --------------------

    // async read, the stream stage registers it
    assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// File: rtl/hv_generator.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_defs.svh"

module hv_generator (
    input  logic               AXIS_ACLK,
    input  logic               S_AXI_ARESETN,
    input  hdc_pkg::hdc_ctrl_t ctrl,
    output hdc_pkg::hv_write_t wr,
    output logic               gen_done
);

    logic [`WORD_WIDTH-1:0]      xs_state;
    logic [`WORD_WIDTH-1:0]      xs_next;
    logic [`WORD_IDX_WIDTH-1:0]  word_idx;
    logic [`ITEM_ADDR_WIDTH-1:0] item_addr;
    logic [`HV_WIDTH-1:0]        hv_asm;
    logic [`HV_WIDTH-1:0]        hv_asm_next;
    logic                        last_word;

    // xorshift32, shifts 13 / 17 / 5
    function automatic logic [`WORD_WIDTH-1:0] xorshift_step(input logic [`WORD_WIDTH-1:0] x);
        logic [`WORD_WIDTH-1:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign xs_next   = xorshift_step(xs_state);
    assign last_word = (word_idx == `WORD_IDX_WIDTH'(`HV_WORDS - 1));

    // drop the fresh word into its slot, word 0 lowest
    always_comb begin
        hv_asm_next = hv_asm;
        hv_asm_next[word_idx * `WORD_WIDTH +: `WORD_WIDTH] = xs_next;
    end

    // --------------------
    // control counters
    // --------------------
    always_ff @(posedge AXIS_ACLK) begin
        // held at seed and zero outside gen
        if (!S_AXI_ARESETN || !ctrl.gen) begin
            xs_state  <= `XORSHIFT_SEED;
            word_idx  <= '0;
            item_addr <= '0;
            wr.valid  <= 1'b0;
            wr.addr   <= '0;
            gen_done  <= 1'b0;
        end else begin
            xs_state <= xs_next;
            word_idx <= word_idx + 1'b1;
            // eighth word in, write goes out next cycle
            wr.valid <= last_word;
            wr.addr  <= item_addr;
            gen_done <= last_word && (item_addr == ctrl.item_count);
            if (last_word) begin
                item_addr <= item_addr + 1'b1;
            end
        end
    end

    // assembly and write payload
    always_ff @(posedge AXIS_ACLK) begin
        hv_asm <= hv_asm_next;
        if (last_word) begin
            wr.data <= hv_asm_next;
        end
    end

    // items beyond item_count are never written
    a_addr_limit: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        wr.valid |-> (wr.addr <= ctrl.item_count));

endmodule

`default_nettype wire

// File: rtl/axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_defs.svh"

module axil_regs (
    input  logic              AXIS_ACLK,
    input  logic              S_AXI_ARESETN,

    // write address
    input  logic [31:0]       S_AXI_AWADDR,
    input  logic              S_AXI_AWVALID,
    output logic              S_AXI_AWREADY,

    // write data
    input  logic [31:0]       S_AXI_WDATA,
    input  logic [3:0]        S_AXI_WSTRB,
    input  logic              S_AXI_WVALID,
    output logic              S_AXI_WREADY,

    // write response
    input  logic              S_AXI_BREADY,
    output logic [1:0]        S_AXI_BRESP,
    output logic              S_AXI_BVALID,

    // read address
    input  logic [31:0]       S_AXI_ARADDR,
    input  logic              S_AXI_ARVALID,
    output logic              S_AXI_ARREADY,

    // read data
    input  logic              S_AXI_RREADY,
    output logic [31:0]       S_AXI_RDATA,
    output logic [1:0]        S_AXI_RRESP,
    output logic              S_AXI_RVALID,

    // last item written by the generator
    input  logic              gen_done,
    output hdc_pkg::hdc_ctrl_t ctrl
);

    hdc_pkg::axil_state_e state;

    // word addresses only, low two bits dropped
    logic [`REG_ADDR_WIDTH-1:2] write_addr;
    logic [`REG_ADDR_WIDTH-1:2] read_addr;
    // both registers live in byte 0
    logic [7:0]                 write_data;
    logic                       write_strb;
    logic                       reg_write;

    // --------------------
    // handshake outputs
    // --------------------
    assign S_AXI_AWREADY = (state == hdc_pkg::st_init) || (state == hdc_pkg::st_w);
    assign S_AXI_WREADY  = (state == hdc_pkg::st_init) || (state == hdc_pkg::st_aw);
    // writes win in init, so no read accept while a write is offered
    assign S_AXI_ARREADY = (state == hdc_pkg::st_init) && !S_AXI_AWVALID && !S_AXI_WVALID;
    assign S_AXI_BVALID  = (state == hdc_pkg::st_aww);
    assign S_AXI_RVALID  = (state == hdc_pkg::st_ar2);
    // always OKAY
    assign S_AXI_BRESP   = 2'b00;
    assign S_AXI_RRESP   = 2'b00;

    // --------------------
    // slave state machine
    // --------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= hdc_pkg::st_init;
        end else begin
            case (state)
                hdc_pkg::st_init: begin
                    if (S_AXI_AWVALID && S_AXI_WVALID) begin
                        state <= hdc_pkg::st_aww;
                    end else if (S_AXI_AWVALID) begin
                        state <= hdc_pkg::st_aw;
                    end else if (S_AXI_WVALID) begin
                        state <= hdc_pkg::st_w;
                    end else if (S_AXI_ARVALID) begin
                        state <= hdc_pkg::st_ar1;
                    end
                end
                // address seen, wait for data
                hdc_pkg::st_aw: if (S_AXI_WVALID) state <= hdc_pkg::st_aww;
                // data seen, wait for address
                hdc_pkg::st_w: if (S_AXI_AWVALID) state <= hdc_pkg::st_aww;
                hdc_pkg::st_aww: if (S_AXI_BREADY) state <= hdc_pkg::st_init;
                // one cycle to look up the read data
                hdc_pkg::st_ar1: state <= hdc_pkg::st_ar2;
                hdc_pkg::st_ar2: if (S_AXI_RREADY) state <= hdc_pkg::st_init;
                default: state <= hdc_pkg::st_init;
            endcase
        end
    end

    // address and data capture on each accepted half
    always_ff @(posedge AXIS_ACLK) begin
        if (S_AXI_AWVALID && S_AXI_AWREADY) begin
            write_addr <= S_AXI_AWADDR[`REG_ADDR_WIDTH-1:2];
        end
        if (S_AXI_WVALID && S_AXI_WREADY) begin
            write_data <= S_AXI_WDATA[7:0];
            write_strb <= S_AXI_WSTRB[0];
        end
        if (S_AXI_ARVALID && S_AXI_ARREADY) begin
            read_addr <= S_AXI_ARADDR[`REG_ADDR_WIDTH-1:2];
        end
    end

    // update on the edge leaving aww
    assign reg_write = (state == hdc_pkg::st_aww) && S_AXI_BREADY && write_strb;

    // --------------------
    // mode and count
    // --------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            ctrl <= '0;
        end else begin
            // generator finished, gen drops by itself
            if (gen_done) begin
                ctrl.gen <= 1'b0;
            end
            // a bus write takes priority over gen_done
            if (reg_write && ({write_addr, 2'b00} == `REG_MODE_ADDR)) begin
                ctrl.gen <= write_data[0];
                ctrl.run <= write_data[1];
            end
            if (reg_write && ({write_addr, 2'b00} == `REG_COUNT_ADDR)) begin
                ctrl.item_count <= write_data[`ITEM_ADDR_WIDTH-1:0];
            end
        end
    end

    // readback, registered on the edge into ar2
    always_ff @(posedge AXIS_ACLK) begin
        if (state == hdc_pkg::st_ar1) begin
            case ({read_addr, 2'b00})
                `REG_MODE_ADDR:  S_AXI_RDATA <= 32'({ctrl.run, ctrl.gen});
                `REG_COUNT_ADDR: S_AXI_RDATA <= 32'(ctrl.item_count);
                default:         S_AXI_RDATA <= '0;
            endcase
        end
    end

    // generator must not report done outside gen
    a_done_in_gen: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        gen_done |-> ctrl.gen);

endmodule

`default_nettype wire

// File: rtl/hdc_pkg.sv
`include "hdc_defs.svh"

package hdc_pkg;

    // axi-lite slave states
    typedef enum logic [2:0] {
        st_init = 3'd0,
        st_aw   = 3'd1,
        st_w    = 3'd2,
        st_aww  = 3'd3,
        st_ar1  = 3'd4,
        st_ar2  = 3'd5
    } axil_state_e;

    // mode from the register block, 8 bits
    typedef struct packed {
        logic                        gen;
        logic                        run;
        logic [`ITEM_ADDR_WIDTH-1:0] item_count;
    } hdc_ctrl_t;

    // item memory write, 263 bits
    typedef struct packed {
        logic                        valid;
        logic [`ITEM_ADDR_WIDTH-1:0] addr;
        logic [`HV_WIDTH-1:0]        data;
    } hv_write_t;

    // one stream beat, 257 bits
    typedef struct packed {
        logic [`HV_WIDTH-1:0] data;
        logic                 last;
    } hv_beat_t;

endpackage

// File: rtl/hdc_defs.svh
`ifndef HDC_DEFS_SVH
`define HDC_DEFS_SVH

// --------------------
// hypervector sizes
// --------------------

// one hypervector, also the stream data width
`define HV_WIDTH        256
// xorshift output word
`define WORD_WIDTH      32
`define HV_WORDS        8
`define WORD_IDX_WIDTH  3

// item memory
`define ITEM_DEPTH      64
`define ITEM_ADDR_WIDTH 6

// --------------------
// register map
// --------------------
`define REG_ADDR_WIDTH  12
`define REG_MODE_ADDR   12'h000
`define REG_COUNT_ADDR  12'h004

// classic xorshift32 start value
`define XORSHIFT_SEED   32'd2463534242

`endif
